/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = tb_key_extract
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) source/key_ex_cfg.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
+incdir+source
source/key_ex_pkg.sv
source/key_table.sv
source/predicate_unit.sv
source/key_extract_ctrl.sv
source/key_extract.sv
verif/tb_key_extract.sv

/* source/key_ex_cfg.svh */
`ifndef KEY_EX_CFG_SVH
`define KEY_EX_CFG_SVH

// container widths in bits
`define KE_C6_W        48
`define KE_C4_W        32
`define KE_C2_W        16
`define KE_NCONT       8
`define KE_META_W      256
`define KE_PHV_W       1024

// key is two slots per class plus the predicate bit
`define KE_KEY_W       193
`define KE_OFF_W       38
`define KE_CIDX_W      3
`define KE_CMP_W       20

// table depth and index
`define KE_IDX_W       5
`define KE_NENTRY      32

// wishbone
`define KE_WB_AW       11
`define KE_WB_DW       32
`define KE_OFF_WORDS   2
`define KE_MASK_WORDS  7

// address fields: table select, entry, word within entry
`define KE_WB_SEL_BIT  10
`define KE_WB_ENT_HI   9
`define KE_WB_ENT_LO   5
`define KE_WB_WORD_HI  2
`define KE_WB_WORD_LO  0

`endif

/* source/key_ex_pkg.sv */
`include "key_ex_cfg.svh"

package key_ex_pkg;

    // container 7 of each class sits highest, metadata at the bottom
    typedef struct packed {
        logic [`KE_NCONT-1:0][`KE_C6_W-1:0] c6;
        logic [`KE_NCONT-1:0][`KE_C4_W-1:0] c4;
        logic [`KE_NCONT-1:0][`KE_C2_W-1:0] c2;
        logic [`KE_META_W-1:0]              meta;
    } phv_t;

    // same layout for key and mask
    typedef struct packed {
        logic [`KE_C6_W-1:0] s6_0;
        logic [`KE_C6_W-1:0] s6_1;
        logic [`KE_C4_W-1:0] s4_0;
        logic [`KE_C4_W-1:0] s4_1;
        logic [`KE_C2_W-1:0] s2_0;
        logic [`KE_C2_W-1:0] s2_1;
        logic                pred;
    } key_t;

    // one container index per key slot, then the compare field
    typedef struct packed {
        logic [`KE_CIDX_W-1:0] idx6_0;
        logic [`KE_CIDX_W-1:0] idx6_1;
        logic [`KE_CIDX_W-1:0] idx4_0;
        logic [`KE_CIDX_W-1:0] idx4_1;
        logic [`KE_CIDX_W-1:0] idx2_0;
        logic [`KE_CIDX_W-1:0] idx2_1;
        logic [`KE_CMP_W-1:0]  cmp;
    } off_entry_t;

    typedef enum logic [1:0] {
        CMP_GT     = 2'd0,
        CMP_GE     = 2'd1,
        CMP_EQ     = 2'd2,
        CMP_ALWAYS = 2'd3
    } cmp_op_e;

    typedef enum logic [1:0] {
        CLS_2B   = 2'd0,
        CLS_4B   = 2'd1,
        CLS_6B   = 2'd2,
        CLS_NONE = 2'd3
    } cont_class_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_OPERAND,
        ST_ASSEMBLE,
        ST_HOLD
    } ctrl_state_e;

endpackage

/* source/key_extract.sv */
`timescale 1ns/10ps
`include "key_ex_cfg.svh"

module key_extract (
    input  logic                 clk,
    input  logic                 rst_n,

    // PHV input
    input  logic [`KE_PHV_W-1:0] phv_in,
    input  logic [`KE_IDX_W-1:0] phv_index,
    input  logic                 phv_valid,
    output logic                 phv_ready,

    // key output
    output logic [`KE_PHV_W-1:0] out_phv,
    output logic [`KE_KEY_W-1:0] out_key,
    output logic [`KE_KEY_W-1:0] out_key_mask,
    output logic [`KE_KEY_W-1:0] out_key_masked,
    output logic                 out_valid,
    input  logic                 out_ready,

    // wishbone slave for the tables
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`KE_WB_AW-1:0] wb_adr,
    input  logic [`KE_WB_DW-1:0] wb_dat_w,
    output logic [`KE_WB_DW-1:0] wb_dat_r,
    output logic                 wb_ack
);

    logic [`KE_IDX_W-1:0]          lookup_index;
    logic [`KE_OFF_W-1:0]          off_entry;
    logic [`KE_KEY_W-1:0]          mask_entry;
    logic [`KE_CMP_W-1:0]          cmp_field;
    logic [`KE_NCONT*`KE_C6_W-1:0] cont_6b;
    logic [`KE_NCONT*`KE_C4_W-1:0] cont_4b;
    logic [`KE_NCONT*`KE_C2_W-1:0] cont_2b;
    logic                          load;
    logic                          pred;

    key_table u_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .lookup_index (lookup_index),
        .off_entry    (off_entry),
        .mask_entry   (mask_entry)
    );

    key_extract_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_index      (phv_index),
        .phv_valid      (phv_valid),
        .phv_ready      (phv_ready),
        .lookup_index   (lookup_index),
        .off_entry      (off_entry),
        .mask_entry     (mask_entry),
        .cmp_field      (cmp_field),
        .cont_6b        (cont_6b),
        .cont_4b        (cont_4b),
        .cont_2b        (cont_2b),
        .load           (load),
        .pred           (pred),
        .out_phv        (out_phv),
        .out_key        (out_key),
        .out_key_mask   (out_key_mask),
        .out_key_masked (out_key_masked),
        .out_valid      (out_valid),
        .out_ready      (out_ready)
    );

    predicate_unit u_pred (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .cmp_field (cmp_field),
        .cont_6b   (cont_6b),
        .cont_4b   (cont_4b),
        .cont_2b   (cont_2b),
        .pred      (pred)
    );

endmodule

/* source/key_extract_ctrl.sv */
`timescale 1ns/10ps
`include "key_ex_cfg.svh"

module key_extract_ctrl
    import key_ex_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,

    // PHV input handshake
    input  phv_t                          phv_in,
    input  logic [`KE_IDX_W-1:0]          phv_index,
    input  logic                          phv_valid,
    output logic                          phv_ready,

    // table lookup
    output logic [`KE_IDX_W-1:0]          lookup_index,
    input  off_entry_t                    off_entry,
    input  key_t                          mask_entry,

    // predicate unit
    output logic [`KE_CMP_W-1:0]          cmp_field,
    output logic [`KE_NCONT*`KE_C6_W-1:0] cont_6b,
    output logic [`KE_NCONT*`KE_C4_W-1:0] cont_4b,
    output logic [`KE_NCONT*`KE_C2_W-1:0] cont_2b,
    output logic                          load,
    input  logic                          pred,

    // output handshake
    output phv_t                          out_phv,
    output key_t                          out_key,
    output key_t                          out_key_mask,
    output key_t                          out_key_masked,
    output logic                          out_valid,
    input  logic                          out_ready
);

    ctrl_state_e state;
    off_entry_t  off_r;
    key_t        mask_r;
    key_t        key_next;
    logic        accept;

    assign accept = (state == ST_IDLE) && phv_valid && phv_ready;

    // banks come straight off the held PHV
    assign cont_6b = out_phv.c6;
    assign cont_4b = out_phv.c4;
    assign cont_2b = out_phv.c2;

    assign cmp_field = off_r.cmp;
    assign load      = (state == ST_OPERAND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            phv_ready <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // index reaches the table during the cycle after accept
                    if (accept) begin
                        phv_ready <= 1'b0;
                    end else if (!phv_ready) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state <= ST_OPERAND;
                end
                ST_OPERAND: begin
                    state <= ST_ASSEMBLE;
                end
                ST_ASSEMBLE: begin
                    out_valid <= 1'b1;
                    state     <= ST_HOLD;
                end
                ST_HOLD: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        phv_ready <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // slot gather by the latched offset entry
    always_comb begin
        key_next.s6_0 = out_phv.c6[off_r.idx6_0];
        key_next.s6_1 = out_phv.c6[off_r.idx6_1];
        key_next.s4_0 = out_phv.c4[off_r.idx4_0];
        key_next.s4_1 = out_phv.c4[off_r.idx4_1];
        key_next.s2_0 = out_phv.c2[off_r.idx2_0];
        key_next.s2_1 = out_phv.c2[off_r.idx2_1];
        key_next.pred = pred;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_phv      <= phv_in;
            lookup_index <= phv_index;
        end
        // table output is fresh here
        if (state == ST_LOOKUP) begin
            off_r  <= off_entry;
            mask_r <= mask_entry;
        end
        if (state == ST_ASSEMBLE) begin
            out_key        <= key_next;
            out_key_mask   <= mask_r;
            out_key_masked <= key_next & ~mask_r;
        end
    end

endmodule

/* source/key_table.sv */
`timescale 1ns/10ps
`include "key_ex_cfg.svh"

module key_table
    import key_ex_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`KE_WB_AW-1:0] wb_adr,
    input  logic [`KE_WB_DW-1:0] wb_dat_w,
    output logic [`KE_WB_DW-1:0] wb_dat_r,
    output logic                 wb_ack,
    input  logic [`KE_IDX_W-1:0] lookup_index,
    output off_entry_t           off_entry,
    output key_t                 mask_entry
);

    localparam int WORD_AW = `KE_WB_WORD_HI - `KE_WB_WORD_LO + 1;
    localparam int VIEW_W  = (2 ** WORD_AW) * `KE_WB_DW;

    logic [`KE_OFF_W-1:0] off_mem  [`KE_NENTRY];
    logic [`KE_KEY_W-1:0] mask_mem [`KE_NENTRY];

    logic                 sel_mask;
    logic [`KE_IDX_W-1:0] wb_entry;
    logic [WORD_AW-1:0]   wb_word;
    logic                 wb_req;
    logic [VIEW_W-1:0]    off_view;
    logic [VIEW_W-1:0]    mask_view;
    logic [VIEW_W-1:0]    off_merged;
    logic [VIEW_W-1:0]    mask_merged;

    assign sel_mask = wb_adr[`KE_WB_SEL_BIT];
    assign wb_entry = wb_adr[`KE_WB_ENT_HI:`KE_WB_ENT_LO];
    assign wb_word  = wb_adr[`KE_WB_WORD_HI:`KE_WB_WORD_LO];

    // a request that has not been acked yet
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    // entries zero-extended over the whole word range,
    // so words past the entry width read back as zero
    assign off_view  = VIEW_W'(off_mem[wb_entry]);
    assign mask_view = VIEW_W'(mask_mem[wb_entry]);

    always_comb begin
        off_merged  = off_view;
        mask_merged = mask_view;
        off_merged[wb_word*`KE_WB_DW +: `KE_WB_DW]  = wb_dat_w;
        mask_merged[wb_word*`KE_WB_DW +: `KE_WB_DW] = wb_dat_w;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // one 32-bit word per write, high bits of the last word dropped
    always_ff @(posedge clk) begin
        if (wb_req && wb_we) begin
            if (!sel_mask && wb_word < `KE_OFF_WORDS) begin
                off_mem[wb_entry] <= off_merged[`KE_OFF_W-1:0];
            end
            if (sel_mask && wb_word < `KE_MASK_WORDS) begin
                mask_mem[wb_entry] <= mask_merged[`KE_KEY_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            if (sel_mask) begin
                wb_dat_r <= mask_view[wb_word*`KE_WB_DW +: `KE_WB_DW];
            end else begin
                wb_dat_r <= off_view[wb_word*`KE_WB_DW +: `KE_WB_DW];
            end
        end
    end

    // lookup port, registered every cycle
    always_ff @(posedge clk) begin
        off_entry  <= off_mem[lookup_index];
        mask_entry <= mask_mem[lookup_index];
    end

endmodule

/* source/predicate_unit.sv */
`timescale 1ns/10ps
`include "key_ex_cfg.svh"

module predicate_unit
    import key_ex_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load,
    input  logic [`KE_CMP_W-1:0]          cmp_field,
    input  logic [`KE_NCONT*`KE_C6_W-1:0] cont_6b,
    input  logic [`KE_NCONT*`KE_C4_W-1:0] cont_4b,
    input  logic [`KE_NCONT*`KE_C2_W-1:0] cont_2b,
    output logic                          pred
);

    cmp_op_e    op_q;
    logic [7:0] opa_q;
    logic [7:0] opb_q;
    logic [7:0] opa_sel;
    logic [7:0] opb_sel;

    // immediate, or low byte of the indexed container
    function automatic logic [7:0] pick_operand(
        input logic                  is_imm,
        input logic [7:0]            imm,
        input logic [1:0]            cls,
        input logic [`KE_CIDX_W-1:0] idx
    );
        logic [7:0] val;
        if (is_imm) begin
            val = imm;
        end else begin
            case (cont_class_e'(cls))
                CLS_6B:  val = cont_6b[idx*`KE_C6_W +: 8];
                CLS_4B:  val = cont_4b[idx*`KE_C4_W +: 8];
                CLS_2B:  val = cont_2b[idx*`KE_C2_W +: 8];
                default: val = 8'd0;
            endcase
        end
        return val;
    endfunction

    // A immediate overlaps its class and index bits
    always_comb begin
        opa_sel = pick_operand(cmp_field[17], cmp_field[16:9],
                               cmp_field[13:12], cmp_field[11:9]);
        opb_sel = pick_operand(cmp_field[8], cmp_field[7:0],
                               cmp_field[4:3], cmp_field[2:0]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q  <= CMP_ALWAYS;
            opa_q <= 8'd0;
            opb_q <= 8'd0;
        end else if (load) begin
            op_q  <= cmp_op_e'(cmp_field[19:18]);
            opa_q <= opa_sel;
            opb_q <= opb_sel;
        end
    end

    always_comb begin
        case (op_q)
            CMP_GT:  pred = opa_q > opb_q;
            CMP_GE:  pred = opa_q >= opb_q;
            CMP_EQ:  pred = opa_q == opb_q;
            default: pred = 1'b1;
        endcase
    end

endmodule

/* verif/tb_key_extract.sv */
`timescale 1ns/10ps
`include "key_ex_cfg.svh"

module tb_key_extract
    import key_ex_pkg::*;
();

    // container banks sit above the metadata with the 2-byte bank lowest
    localparam int C2_BASE     = `KE_META_W;
    localparam int C4_BASE     = C2_BASE + `KE_NCONT * `KE_C2_W;
    localparam int C6_BASE     = C4_BASE + `KE_NCONT * `KE_C4_W;
    localparam int WAIT_LIMIT  = 50;
    localparam int NUM_PACKETS = 80;

    logic                 clk;
    logic                 rst_n;
    logic [`KE_PHV_W-1:0] phv_in;
    logic [`KE_IDX_W-1:0] phv_index;
    logic                 phv_valid;
    logic                 phv_ready;
    logic [`KE_PHV_W-1:0] out_phv;
    logic [`KE_KEY_W-1:0] out_key;
    logic [`KE_KEY_W-1:0] out_key_mask;
    logic [`KE_KEY_W-1:0] out_key_masked;
    logic                 out_valid;
    logic                 out_ready;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [`KE_WB_AW-1:0] wb_adr;
    logic [`KE_WB_DW-1:0] wb_dat_w;
    logic [`KE_WB_DW-1:0] wb_dat_r;
    logic                 wb_ack;

    // reference copy of both tables
    logic [`KE_OFF_W-1:0] off_model  [`KE_NENTRY];
    logic [`KE_KEY_W-1:0] mask_model [`KE_NENTRY];
    logic [31:0]          rng_state;
    int                   check_count;
    int                   mismatch_count;
    int                   timeout_count;

    key_extract UUT (
        .clk(clk), .rst_n(rst_n),
        .phv_in(phv_in), .phv_index(phv_index), .phv_valid(phv_valid), .phv_ready(phv_ready),
        .out_phv(out_phv), .out_key(out_key), .out_key_mask(out_key_mask),
        .out_key_masked(out_key_masked), .out_valid(out_valid), .out_ready(out_ready),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [`KE_C6_W-1:0] c6_of(input logic [`KE_PHV_W-1:0] p,
                                                  input logic [2:0] i);
        return p[C6_BASE + i*`KE_C6_W +: `KE_C6_W];
    endfunction

    function automatic logic [`KE_C4_W-1:0] c4_of(input logic [`KE_PHV_W-1:0] p,
                                                  input logic [2:0] i);
        return p[C4_BASE + i*`KE_C4_W +: `KE_C4_W];
    endfunction

    function automatic logic [`KE_C2_W-1:0] c2_of(input logic [`KE_PHV_W-1:0] p,
                                                  input logic [2:0] i);
        return p[C2_BASE + i*`KE_C2_W +: `KE_C2_W];
    endfunction

    function automatic logic [7:0] operand_byte(input logic [`KE_PHV_W-1:0] p,
            input logic is_imm, input logic [7:0] imm, input logic [1:0] cls,
            input logic [2:0] idx);
        logic [47:0] c;
        if (is_imm) begin
            return imm;
        end
        case (cont_class_e'(cls))
            CLS_2B:  c = 48'(c2_of(p, idx));
            CLS_4B:  c = 48'(c4_of(p, idx));
            CLS_6B:  c = c6_of(p, idx);
            default: c = '0;
        endcase
        return c[7:0];
    endfunction

    function automatic logic expected_pred(input logic [`KE_PHV_W-1:0] p,
                                           input logic [19:0] cmp);
        logic [7:0] a;
        logic [7:0] b;
        a = operand_byte(p, cmp[17], cmp[16:9], cmp[13:12], cmp[11:9]);
        b = operand_byte(p, cmp[8], cmp[7:0], cmp[4:3], cmp[2:0]);
        case (cmp_op_e'(cmp[19:18]))
            CMP_GT:  return a > b;
            CMP_GE:  return a >= b;
            CMP_EQ:  return a == b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic key_t expected_key(input logic [`KE_PHV_W-1:0] p,
                                          input logic [`KE_OFF_W-1:0] off);
        key_t k;
        k.s6_0 = c6_of(p, off[37:35]);
        k.s6_1 = c6_of(p, off[34:32]);
        k.s4_0 = c4_of(p, off[31:29]);
        k.s4_1 = c4_of(p, off[28:26]);
        k.s2_0 = c2_of(p, off[25:23]);
        k.s2_1 = c2_of(p, off[22:20]);
        k.pred = expected_pred(p, off[19:0]);
        return k;
    endfunction

    // words past the entry width come back as zero
    function automatic logic [31:0] model_word(input logic sel, input logic [4:0] ent,
                                               input logic [2:0] word);
        logic [255:0] view;
        if (sel) begin
            view = 256'(mask_model[ent]);
        end else begin
            view = 256'(off_model[ent]);
        end
        return view[word*32 +: 32];
    endfunction

    task automatic check_key(input string name, input key_t got, input key_t exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_phv(input string name, input phv_t got, input phv_t exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_report(input logic timed_out);
        $display("checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_count, mismatch_count, timeout_count);
        if (!timed_out && mismatch_count == 0 && timeout_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // one classic cycle with the ack expected on the next edge
    task automatic wb_cycle(input logic we, input logic [`KE_WB_AW-1:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        cycles   = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_ack && cycles < WAIT_LIMIT);
        if (!wb_ack) begin
            timeout_count++;
            $display("timeout: wb_ack never came for address %h", adr);
        end else begin
            check_word("wb_ack delay", cycles, 32'd1);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic sel, input logic [4:0] ent, input logic [2:0] word,
                            input logic [31:0] data);
        logic [255:0] view;
        logic [31:0]  rd_unused;
        if (sel && word < `KE_MASK_WORDS) begin
            view                 = 256'(mask_model[ent]);
            view[word*32 +: 32]  = data;
            mask_model[ent]      = view[`KE_KEY_W-1:0];
        end else if (!sel && word < `KE_OFF_WORDS) begin
            view                 = 256'(off_model[ent]);
            view[word*32 +: 32]  = data;
            off_model[ent]       = view[`KE_OFF_W-1:0];
        end
        wb_cycle(1'b1, {sel, ent, 2'b00, word}, data, rd_unused);
    endtask

    task automatic read_entry(input logic sel, input logic [4:0] ent);
        logic [31:0] rd;
        for (int w = 0; w < 8; w++) begin
            wb_cycle(1'b0, {sel, ent, 2'b00, 3'(w)}, 32'd0, rd);
            check_word($sformatf("wb_dat_r table %0d entry %0d word %0d", sel, ent, w),
                       rd, model_word(sel, ent, 3'(w)));
        end
    endtask

    task automatic run_packet(input logic hold_output);
        logic [`KE_PHV_W-1:0] phv;
        logic [`KE_OFF_W-1:0] off;
        logic [4:0]           idx;
        logic [31:0]          r;
        key_t                 exp_key;
        key_t                 exp_mask;
        int                   lat;
        int                   hold;
        for (int i = 0; i < `KE_PHV_W / 32; i++) begin
            phv[i*32 +: 32] = next_rand();
        end
        r   = next_rand();
        idx = r[4:0];
        off = {r[31:26], next_rand()};
        // steer some entries onto equal operands
        case (r[9:8])
            2'd1: begin
                off[17]  = 1'b0;
                off[8]   = 1'b0;
                off[4:0] = off[13:9];
            end
            2'd2: begin
                off[17]  = 1'b0;
                off[8]   = 1'b1;
                off[7:0] = operand_byte(phv, 1'b0, 8'd0, off[13:12], off[11:9]);
            end
            2'd3: begin
                off[17]    = 1'b0;
                off[13:12] = 2'd3;
                off[8]     = 1'b1;
                off[7:0]   = 8'd0;
            end
            default: begin
            end
        endcase
        wb_write(1'b0, idx, 3'd0, off[31:0]);
        wb_write(1'b0, idx, 3'd1, {r[25:0], off[37:32]});
        for (int w = 0; w < `KE_MASK_WORDS; w++) begin
            wb_write(1'b1, idx, 3'(w), next_rand());
        end
        exp_key  = expected_key(phv, off_model[idx]);
        exp_mask = key_t'(mask_model[idx]);

        @(negedge clk);
        phv_in    = phv;
        phv_index = idx;
        phv_valid = 1'b1;
        out_ready = !hold_output;
        lat       = 0;
        while (!phv_ready && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (!phv_ready) begin
            timeout_count++;
            $display("timeout: phv_ready stayed low before a new PHV");
            phv_valid = 1'b0;
            return;
        end
        // accepted on this edge; under hold a second PHV keeps knocking
        @(negedge clk);
        if (hold_output) begin
            phv_in    = ~phv;
            phv_index = ~idx;
        end else begin
            phv_valid = 1'b0;
        end
        lat = 0;
        while (!out_valid && lat < WAIT_LIMIT) begin
            check_word("phv_ready while busy", 32'(phv_ready), 32'd0);
            @(negedge clk);
            lat++;
        end
        if (!out_valid) begin
            timeout_count++;
            $display("timeout: out_valid never rose after the PHV was accepted");
            phv_valid = 1'b0;
            return;
        end
        check_word("out_valid latency", lat, 32'd4);

        hold = hold_output ? int'(next_rand() % 32'd6) + 1 : 0;
        for (int c = 0; c <= hold; c++) begin
            if (c == hold) begin
                out_ready = 1'b1;
            end
            check_word("phv_ready while holding", 32'(phv_ready), 32'd0);
            check_word("out_valid", 32'(out_valid), 32'd1);
            check_key("out_key", key_t'(out_key), exp_key);
            check_key("out_key_mask", key_t'(out_key_mask), exp_mask);
            check_key("out_key_masked", key_t'(out_key_masked), key_t'(exp_key & ~exp_mask));
            check_phv("out_phv", phv_t'(out_phv), phv_t'(phv));
            if (c < hold) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        phv_valid = 1'b0;
        check_word("out_valid after transfer", 32'(out_valid), 32'd0);
        check_word("phv_ready after transfer", 32'(phv_ready), 32'd1);
    endtask

    initial begin
        #5_000_000;
        $display("watchdog expired before the test sequence finished");
        finish_report(1'b1);
    end

    initial begin
        logic [31:0] r;
        rng_state      = 32'hd03;
        check_count    = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        rst_n          = 1'b0;
        phv_in         = '0;
        phv_index      = '0;
        phv_valid      = 1'b0;
        out_ready      = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        repeat (5) @(negedge clk);
        check_word("out_valid in reset", 32'(out_valid), 32'd0);
        check_word("wb_ack in reset", 32'(wb_ack), 32'd0);
        check_word("phv_ready in reset", 32'(phv_ready), 32'd1);
        rst_n = 1'b1;

        // every word of every entry gets a value first
        for (int e = 0; e < `KE_NENTRY; e++) begin
            for (int w = 0; w < `KE_OFF_WORDS; w++) begin
                wb_write(1'b0, 5'(e), 3'(w), next_rand());
            end
            for (int w = 0; w < `KE_MASK_WORDS; w++) begin
                wb_write(1'b1, 5'(e), 3'(w), next_rand());
            end
        end
        for (int e = 0; e < `KE_NENTRY; e++) begin
            read_entry(1'b0, 5'(e));
            read_entry(1'b1, 5'(e));
        end

        // single words, some of them past the end of the entry
        for (int n = 0; n < 40; n++) begin
            r = next_rand();
            wb_write(r[0], r[5:1], r[8:6], next_rand());
            read_entry(r[0], r[5:1]);
        end

        for (int p = 0; p < NUM_PACKETS && timeout_count == 0; p++) begin
            r = next_rand();
            run_packet(r[0]);
        end
        finish_report(1'b0);
    end

endmodule
